// ==== soc_pkg.sv ====
////////////////////////////////////////
// Memory map, bus widths and shared enums for the peripheral SoC.
// Imported by every RTL module.
////////////////////////////////////////

package soc_pkg;

  // Bus widths
  localparam int unsigned addr_width     = 32;
  localparam int unsigned data_width     = 64;
  localparam int unsigned strb_width     = data_width / 8;
  localparam int unsigned apb_data_width = 32;

  ////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////

  localparam logic [addr_width-1:0] dram_base   = 32'h8000_0000;
  localparam logic [addr_width-1:0] dram_length = 32'h4000_0000;
  localparam logic [addr_width-1:0] uart_base   = 32'hC000_0000;
  localparam logic [addr_width-1:0] uart_length = 32'h0000_1000;
  localparam logic [addr_width-1:0] ctrl_base   = 32'hD000_0000;
  localparam logic [addr_width-1:0] ctrl_length = 32'h0000_1000;

  // Control register offsets
  localparam logic [addr_width-1:0] ctrl_exit_offset   = 32'h0;
  localparam logic [addr_width-1:0] ctrl_cnt_en_offset = 32'h8;

  typedef enum logic [1:0] {slv_l2, slv_uart, slv_ctrl, slv_none} slave_sel_e;

  typedef enum logic [1:0] {xbar_idle, xbar_issue, xbar_wait, xbar_respond} xbar_state_e;

  typedef enum logic [1:0] {apb_idle, apb_setup, apb_access} apb_state_e;

  // Byte-enable merge of new data over a stored word
  function automatic logic [data_width-1:0] merge_bytes(input logic [data_width-1:0] cur_data,
                                                        input logic [data_width-1:0] new_data,
                                                        input logic [strb_width-1:0] be);
    logic [data_width-1:0] result;
    result = cur_data;
    for (int i = 0; i < strb_width; i++) begin
      if (be[i]) result[8*i +: 8] = new_data[8*i +: 8];
    end
    return result;
  endfunction

endpackage

// ==== soc_xbar.sv ====
////////////////////////////////////////
// Address decoder with one outstanding request, routing the master
// to L2, UART or control registers and holding the response.
////////////////////////////////////////
`timescale 1ns/10ps

module soc_xbar import soc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Master side
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic                  req_we_i,
  input  logic [addr_width-1:0] req_addr_i,
  input  logic [data_width-1:0] req_wdata_i,
  input  logic [strb_width-1:0] req_be_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output logic [data_width-1:0] rsp_rdata_o,
  output logic                  rsp_err_o,
  // L2
  output logic                  l2_req_valid_o,
  input  logic                  l2_req_ready_i,
  output logic                  l2_we_o,
  output logic [addr_width-1:0] l2_addr_o,
  output logic [data_width-1:0] l2_wdata_o,
  output logic [strb_width-1:0] l2_be_o,
  input  logic                  l2_rsp_valid_i,
  input  logic [data_width-1:0] l2_rdata_i,
  input  logic                  l2_err_i,
  // UART
  output logic                  uart_req_valid_o,
  input  logic                  uart_req_ready_i,
  output logic                  uart_we_o,
  output logic [addr_width-1:0] uart_addr_o,
  output logic [data_width-1:0] uart_wdata_o,
  output logic [strb_width-1:0] uart_be_o,
  input  logic                  uart_rsp_valid_i,
  input  logic [data_width-1:0] uart_rdata_i,
  input  logic                  uart_err_i,
  // Control registers
  output logic                  ctrl_req_valid_o,
  input  logic                  ctrl_req_ready_i,
  output logic                  ctrl_we_o,
  output logic [addr_width-1:0] ctrl_addr_o,
  output logic [data_width-1:0] ctrl_wdata_o,
  output logic [strb_width-1:0] ctrl_be_o,
  input  logic                  ctrl_rsp_valid_i,
  input  logic [data_width-1:0] ctrl_rdata_i,
  input  logic                  ctrl_err_i
);

  xbar_state_e           state_q;
  slave_sel_e            sel_q, req_sel;
  logic                  issue_q;
  logic                  we_q, err_q;
  logic [addr_width-1:0] addr_q;
  logic [data_width-1:0] wdata_q, rdata_q;
  logic [strb_width-1:0] be_q;
  logic                  slv_ready, slv_rsp_valid, slv_err;
  logic [data_width-1:0] slv_rdata;

  function automatic slave_sel_e decode(input logic [addr_width-1:0] addr);
    if (addr - dram_base < dram_length) return slv_l2;
    if (addr - uart_base < uart_length) return slv_uart;
    if (addr - ctrl_base < ctrl_length) return slv_ctrl;
    return slv_none;
  endfunction

  assign req_sel = decode(req_addr_i);

  // Mux the selected slave back
  always_comb begin
    slv_ready     = 1'b0;
    slv_rsp_valid = 1'b0;
    slv_rdata     = '0;
    slv_err       = 1'b1;
    case (sel_q)
      slv_l2: begin
        slv_ready     = l2_req_ready_i;
        slv_rsp_valid = l2_rsp_valid_i;
        slv_rdata     = l2_rdata_i;
        slv_err       = l2_err_i;
      end
      slv_uart: begin
        slv_ready     = uart_req_ready_i;
        slv_rsp_valid = uart_rsp_valid_i;
        slv_rdata     = uart_rdata_i;
        slv_err       = uart_err_i;
      end
      slv_ctrl: begin
        slv_ready     = ctrl_req_ready_i;
        slv_rsp_valid = ctrl_rsp_valid_i;
        slv_rdata     = ctrl_rdata_i;
        slv_err       = ctrl_err_i;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Transaction FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= xbar_idle;
      sel_q   <= slv_none;
      issue_q <= 1'b0;
    end else begin
      case (state_q)
        xbar_idle: begin
          if (req_valid_i) begin
            sel_q   <= req_sel;
            // Unmapped requests skip the slave entirely
            state_q <= (req_sel == slv_none) ? xbar_respond : xbar_issue;
          end
        end
        xbar_issue: begin
          issue_q <= 1'b1;
          state_q <= xbar_wait;
        end
        xbar_wait: begin
          if (issue_q && slv_ready) issue_q <= 1'b0;
          if (slv_rsp_valid) state_q <= xbar_respond;
        end
        xbar_respond: begin
          if (rsp_ready_i) state_q <= xbar_idle;
        end
        default: state_q <= xbar_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      we_q    <= req_we_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      be_q    <= req_be_i;
      rdata_q <= '0;
      err_q   <= (req_sel == slv_none);
    end else if (state_q == xbar_wait && slv_rsp_valid) begin
      rdata_q <= slv_rdata;
      err_q   <= slv_err;
    end
  end

  assign req_ready_o = (state_q == xbar_idle);
  assign rsp_valid_o = (state_q == xbar_respond);
  assign rsp_rdata_o = rdata_q;
  assign rsp_err_o   = err_q;

  // Request fields are shared, only valid is steered
  assign l2_req_valid_o   = issue_q && (sel_q == slv_l2);
  assign l2_we_o          = we_q;
  assign l2_addr_o        = addr_q;
  assign l2_wdata_o       = wdata_q;
  assign l2_be_o          = be_q;
  assign uart_req_valid_o = issue_q && (sel_q == slv_uart);
  assign uart_we_o        = we_q;
  assign uart_addr_o      = addr_q;
  assign uart_wdata_o     = wdata_q;
  assign uart_be_o        = be_q;
  assign ctrl_req_valid_o = issue_q && (sel_q == slv_ctrl);
  assign ctrl_we_o        = we_q;
  assign ctrl_addr_o      = addr_q;
  assign ctrl_wdata_o     = wdata_q;
  assign ctrl_be_o        = be_q;

endmodule

// ==== l2_mem.sv ====
////////////////////////////////////////
// L2 word memory, single port, byte enables, one-cycle response.
////////////////////////////////////////
`timescale 1ns/10ps

module l2_mem import soc_pkg::*; #(
  parameter int unsigned l2_num_words = 1024
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic                  we_i,
  input  logic [addr_width-1:0] addr_i,
  input  logic [data_width-1:0] wdata_i,
  input  logic [strb_width-1:0] be_i,
  output logic                  rsp_valid_o,
  output logic [data_width-1:0] rdata_o,
  output logic                  err_o
);

  localparam int unsigned idx_width = (l2_num_words > 1) ? $clog2(l2_num_words) : 1;
  localparam int unsigned byte_bits = $clog2(strb_width);

  logic [data_width-1:0] mem_q [l2_num_words];
  logic [data_width-1:0] rdata_q;
  logic [idx_width-1:0]  idx;
  logic                  access;
  logic                  rsp_valid_q;

  assign req_ready_o = 1'b1;
  assign access      = req_valid_i && req_ready_o;
  // Region aliases modulo the array size
  assign idx = idx_width'(addr_i[addr_width-1:byte_bits] % l2_num_words);

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        mem_q[idx] <= merge_bytes(mem_q[idx], wdata_i, be_i);
        rdata_q    <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) rsp_valid_q <= 1'b0;
    else rsp_valid_q <= access;
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;
  assign err_o       = 1'b0;

endmodule

// ==== uart_apb_bridge.sv ====
////////////////////////////////////////
// Bus to APB3 master bridge for the UART, one transfer at a time.
////////////////////////////////////////
`timescale 1ns/10ps

module uart_apb_bridge import soc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      we_i,
  input  logic [addr_width-1:0]     addr_i,
  input  logic [data_width-1:0]     wdata_i,
  output logic                      rsp_valid_o,
  output logic [data_width-1:0]     rdata_o,
  output logic                      err_o,
  // APB master
  output logic                      psel_o,
  output logic                      penable_o,
  output logic                      pwrite_o,
  output logic [addr_width-1:0]     paddr_o,
  output logic [apb_data_width-1:0] pwdata_o,
  input  logic [apb_data_width-1:0] prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i
);

  apb_state_e                state_q;
  logic                      we_q;
  logic [addr_width-1:0]     paddr_q;
  logic [apb_data_width-1:0] pwdata_q;
  logic                      rsp_valid_q;
  logic [data_width-1:0]     rdata_q;
  logic                      err_q;
  logic                      done;

  assign req_ready_o = (state_q == apb_idle);
  assign done        = (state_q == apb_access) && pready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= apb_idle;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= done;
      case (state_q)
        apb_idle:   if (req_valid_i) state_q <= apb_setup;
        apb_setup:  state_q <= apb_access;
        apb_access: if (pready_i) state_q <= apb_idle;
        default:    state_q <= apb_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      we_q     <= we_i;
      // Low 12 bits select the UART register
      paddr_q  <= addr_i & (uart_length - 1);
      pwdata_q <= wdata_i[apb_data_width-1:0];
    end
    if (done) begin
      rdata_q <= we_q ? '0 : data_width'(prdata_i);
      err_q   <= pslverr_i;
    end
  end

  assign psel_o      = (state_q != apb_idle);
  assign penable_o   = (state_q == apb_access);
  assign pwrite_o    = we_q;
  assign paddr_o     = paddr_q;
  assign pwdata_o    = pwdata_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;

endmodule

// ==== ctrl_registers.sv ====
////////////////////////////////////////
// Exit and counter-enable control registers, byte-writable and readable.
////////////////////////////////////////
`timescale 1ns/10ps

module ctrl_registers import soc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic                  we_i,
  input  logic [addr_width-1:0] addr_i,
  input  logic [data_width-1:0] wdata_i,
  input  logic [strb_width-1:0] be_i,
  output logic                  rsp_valid_o,
  output logic [data_width-1:0] rdata_o,
  output logic                  err_o,
  output logic [63:0]           exit_o,
  output logic [63:0]           hw_cnt_en_o
);

  logic [addr_width-1:0] offset;
  logic                  access, hit_exit, hit_cnt_en;
  logic [63:0]           exit_q, cnt_en_q;
  logic                  rsp_valid_q, err_q;
  logic [data_width-1:0] rdata_q;

  assign req_ready_o = 1'b1;
  assign access      = req_valid_i && req_ready_o;
  assign offset      = addr_i & (ctrl_length - 1);
  assign hit_exit    = (offset == ctrl_exit_offset);
  assign hit_cnt_en  = (offset == ctrl_cnt_en_offset);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_q      <= '0;
      cnt_en_q    <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= access;
      if (access && we_i && hit_exit) exit_q <= merge_bytes(exit_q, wdata_i, be_i);
      if (access && we_i && hit_cnt_en) cnt_en_q <= merge_bytes(cnt_en_q, wdata_i, be_i);
    end
  end

  // Unmapped offsets answer with an error and zero data
  always_ff @(posedge clk_i) begin
    if (access) begin
      err_q <= !(hit_exit || hit_cnt_en);
      if (!we_i && hit_exit) rdata_q <= exit_q;
      else if (!we_i && hit_cnt_en) rdata_q <= cnt_en_q;
      else rdata_q <= '0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

// ==== soc_top.sv ====
////////////////////////////////////////
// Peripheral SoC top: one external bus master, L2, UART over APB and
// control registers behind a single-transaction decoder.
////////////////////////////////////////
`timescale 1ns/10ps

module soc_top import soc_pkg::*; #(
  parameter int unsigned l2_num_words = 1024
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Master request
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_we_i,
  input  logic [addr_width-1:0]     req_addr_i,
  input  logic [data_width-1:0]     req_wdata_i,
  input  logic [strb_width-1:0]     req_be_i,
  // Master response
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output logic [data_width-1:0]     rsp_rdata_o,
  output logic                      rsp_err_o,
  // Control outputs
  output logic [63:0]               exit_o,
  output logic [63:0]               hw_cnt_en_o,
  // UART APB
  output logic                      uart_psel_o,
  output logic                      uart_penable_o,
  output logic                      uart_pwrite_o,
  output logic [addr_width-1:0]     uart_paddr_o,
  output logic [apb_data_width-1:0] uart_pwdata_o,
  input  logic [apb_data_width-1:0] uart_prdata_i,
  input  logic                      uart_pready_i,
  input  logic                      uart_pslverr_i
);

  // slv_l2 branch
  logic                  l2_req_valid, l2_req_ready, l2_we, l2_rsp_valid, l2_err;
  logic [addr_width-1:0] l2_addr;
  logic [data_width-1:0] l2_wdata, l2_rdata;
  logic [strb_width-1:0] l2_be;
  // slv_uart branch, no byte enables on APB
  logic                  uart_req_valid, uart_req_ready, uart_we, uart_rsp_valid, uart_err;
  logic [addr_width-1:0] uart_addr;
  logic [data_width-1:0] uart_wdata, uart_rdata;
  // slv_ctrl branch
  logic                  ctrl_req_valid, ctrl_req_ready, ctrl_we, ctrl_rsp_valid, ctrl_err;
  logic [addr_width-1:0] ctrl_addr;
  logic [data_width-1:0] ctrl_wdata, ctrl_rdata;
  logic [strb_width-1:0] ctrl_be;

  soc_xbar i_xbar (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .req_we_i         (req_we_i),
    .req_addr_i       (req_addr_i),
    .req_wdata_i      (req_wdata_i),
    .req_be_i         (req_be_i),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_ready_i      (rsp_ready_i),
    .rsp_rdata_o      (rsp_rdata_o),
    .rsp_err_o        (rsp_err_o),
    .l2_req_valid_o   (l2_req_valid),
    .l2_req_ready_i   (l2_req_ready),
    .l2_we_o          (l2_we),
    .l2_addr_o        (l2_addr),
    .l2_wdata_o       (l2_wdata),
    .l2_be_o          (l2_be),
    .l2_rsp_valid_i   (l2_rsp_valid),
    .l2_rdata_i       (l2_rdata),
    .l2_err_i         (l2_err),
    .uart_req_valid_o (uart_req_valid),
    .uart_req_ready_i (uart_req_ready),
    .uart_we_o        (uart_we),
    .uart_addr_o      (uart_addr),
    .uart_wdata_o     (uart_wdata),
    .uart_be_o        (),
    .uart_rsp_valid_i (uart_rsp_valid),
    .uart_rdata_i     (uart_rdata),
    .uart_err_i       (uart_err),
    .ctrl_req_valid_o (ctrl_req_valid),
    .ctrl_req_ready_i (ctrl_req_ready),
    .ctrl_we_o        (ctrl_we),
    .ctrl_addr_o      (ctrl_addr),
    .ctrl_wdata_o     (ctrl_wdata),
    .ctrl_be_o        (ctrl_be),
    .ctrl_rsp_valid_i (ctrl_rsp_valid),
    .ctrl_rdata_i     (ctrl_rdata),
    .ctrl_err_i       (ctrl_err)
  );

  l2_mem #(
    .l2_num_words (l2_num_words)
  ) i_l2_mem (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (l2_req_valid),
    .req_ready_o (l2_req_ready),
    .we_i        (l2_we),
    .addr_i      (l2_addr),
    .wdata_i     (l2_wdata),
    .be_i        (l2_be),
    .rsp_valid_o (l2_rsp_valid),
    .rdata_o     (l2_rdata),
    .err_o       (l2_err)
  );

  uart_apb_bridge i_uart_bridge (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (uart_req_valid),
    .req_ready_o (uart_req_ready),
    .we_i        (uart_we),
    .addr_i      (uart_addr),
    .wdata_i     (uart_wdata),
    .rsp_valid_o (uart_rsp_valid),
    .rdata_o     (uart_rdata),
    .err_o       (uart_err),
    .psel_o      (uart_psel_o),
    .penable_o   (uart_penable_o),
    .pwrite_o    (uart_pwrite_o),
    .paddr_o     (uart_paddr_o),
    .pwdata_o    (uart_pwdata_o),
    .prdata_i    (uart_prdata_i),
    .pready_i    (uart_pready_i),
    .pslverr_i   (uart_pslverr_i)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (ctrl_req_valid),
    .req_ready_o (ctrl_req_ready),
    .we_i        (ctrl_we),
    .addr_i      (ctrl_addr),
    .wdata_i     (ctrl_wdata),
    .be_i        (ctrl_be),
    .rsp_valid_o (ctrl_rsp_valid),
    .rdata_o     (ctrl_rdata),
    .err_o       (ctrl_err),
    .exit_o      (exit_o),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule

// ==== tb_uart_model.sv ====
////////////////////////////////////////
// APB responder standing in for the UART, with random wait states.
////////////////////////////////////////
`timescale 1ns/10ps

module tb_uart_model (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o
);

  logic [31:0] regs_q [4];
  logic [1:0]  wait_q;
  logic        in_range;

  assign in_range = (paddr_i < 32'h10);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q <= 2'd0;
      for (int i = 0; i < 4; i++) begin
        regs_q[i] <= 32'h0;
      end
    end else begin
      // New wait count picked in the setup phase
      if (psel_i && !penable_i) wait_q <= 2'($urandom % 4);
      else if (psel_i && penable_i && wait_q != 2'd0) wait_q <= wait_q - 2'd1;
      if (pready_o && pwrite_i && in_range) regs_q[paddr_i[3:2]] <= pwdata_i;
    end
  end

  assign pready_o  = psel_i && penable_i && (wait_q == 2'd0);
  assign pslverr_o = pready_o && (paddr_i == 32'hFF0);
  assign prdata_o  = in_range ? regs_q[paddr_i[3:2]] : 32'h0;

endmodule

// ==== tb_soc.sv ====
////////////////////////////////////////
// Testbench for soc_top that runs a table of bus accesses with random
// APB wait states and response back-pressure.
////////////////////////////////////////
`timescale 1ns/10ps

module tb_soc;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  be;
    logic [63:0] exp_rdata;
    logic        exp_err;
  } entry_t;

  logic        clk_i = 1'b0;
  logic        arst_n_i;
  logic        req_valid_i, req_ready_o, req_we_i;
  logic [31:0] req_addr_i;
  logic [63:0] req_wdata_i;
  logic [7:0]  req_be_i;
  logic        rsp_valid_o, rsp_ready_i, rsp_err_o;
  logic [63:0] rsp_rdata_o;
  logic [63:0] exit_o, hw_cnt_en_o;
  logic        uart_psel, uart_penable, uart_pwrite, uart_pready, uart_pslverr;
  logic [31:0] uart_paddr, uart_pwdata, uart_prdata;

  entry_t stim_q[$];
  int     error_cnt = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;
  int     psel_cnt = 0;

  always #10 clk_i = ~clk_i;

  soc_top #(.l2_num_words(1024)) uut (
    .clk_i, .arst_n_i,
    .req_valid_i, .req_ready_o, .req_we_i, .req_addr_i, .req_wdata_i, .req_be_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_rdata_o, .rsp_err_o,
    .exit_o, .hw_cnt_en_o,
    .uart_psel_o    (uart_psel),
    .uart_penable_o (uart_penable),
    .uart_pwrite_o  (uart_pwrite),
    .uart_paddr_o   (uart_paddr),
    .uart_pwdata_o  (uart_pwdata),
    .uart_prdata_i  (uart_prdata),
    .uart_pready_i  (uart_pready),
    .uart_pslverr_i (uart_pslverr)
  );

  tb_uart_model i_uart_model (
    .clk_i, .arst_n_i,
    .psel_i (uart_psel), .penable_i (uart_penable), .pwrite_i (uart_pwrite),
    .paddr_i (uart_paddr), .pwdata_i (uart_pwdata), .prdata_o (uart_prdata),
    .pready_o (uart_pready), .pslverr_o (uart_pslverr)
  );

  always @(posedge clk_i) begin
    if (uart_psel) psel_cnt++;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic add_entry(input logic we, input logic [31:0] addr, input logic [63:0] wdata,
                           input logic [7:0] be, input logic [63:0] exp_rdata,
                           input logic exp_err);
    entry_t e;
    e.we        = we;
    e.addr      = addr;
    e.wdata     = wdata;
    e.be        = be;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    stim_q.push_back(e);
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic fill_table();
    // L2 full and partial writes and an alias through the 8 KiB array
    add_entry(1, 32'h8000_0010, 64'h1122_3344_5566_7788, 8'hFF, 64'h0, 0);
    add_entry(1, 32'h8000_0010, 64'hAABB_CCDD_EEFF_0011, 8'h0F, 64'h0, 0);
    add_entry(0, 32'h8000_0010, 64'h0, 8'hFF, 64'h1122_3344_EEFF_0011, 0);
    add_entry(0, 32'h8000_2010, 64'h0, 8'hFF, 64'h1122_3344_EEFF_0011, 0);
    add_entry(1, 32'h8000_0100, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF, 64'h0, 0);
    add_entry(1, 32'h8000_0100, 64'h1100_0000_0000_0022, 8'h81, 64'h0, 0);
    add_entry(0, 32'h8000_0100, 64'h0, 8'hFF, 64'h11AD_BEEF_CAFE_F022, 0);
    // Control registers with all byte enables
    add_entry(1, 32'hD000_0000, 64'h0000_0000_0000_0001, 8'hFF, 64'h0, 0);
    add_entry(1, 32'hD000_0008, 64'h0000_0000_0000_00FF, 8'hFF, 64'h0, 0);
    add_entry(0, 32'hD000_0000, 64'h0, 8'hFF, 64'h0000_0000_0000_0001, 0);
    add_entry(0, 32'hD000_0008, 64'h0, 8'hFF, 64'h0000_0000_0000_00FF, 0);
    add_entry(0, 32'hD000_0010, 64'h0, 8'hFF, 64'h0, 1);
    // UART over APB with zero-extended reads
    add_entry(1, 32'hC000_0004, 64'hFFFF_FFFF_1234_5678, 8'hFF, 64'h0, 0);
    add_entry(0, 32'hC000_0004, 64'h0, 8'hFF, 64'h0000_0000_1234_5678, 0);
    add_entry(1, 32'hC000_000C, 64'h0000_0000_9ABC_DEF0, 8'hFF, 64'h0, 0);
    add_entry(0, 32'hC000_000C, 64'h0, 8'hFF, 64'h0000_0000_9ABC_DEF0, 0);
    add_entry(0, 32'hC000_0FF0, 64'h0, 8'hFF, 64'h0, 1);
    add_entry(1, 32'hC000_0FF0, 64'h5555_5555, 8'hFF, 64'h0, 1);
    // Unmapped
    add_entry(0, 32'h1000_0000, 64'h0, 8'hFF, 64'h0, 1);
    add_entry(1, 32'h1000_0000, 64'h7777_7777, 8'hFF, 64'h0, 1);
    add_entry(0, 32'hC000_0004, 64'h0, 8'hFF, 64'h0000_0000_1234_5678, 0);
  endtask

  initial begin
    entry_t      e;
    int          errs_before, psel_before, stall, pass_cnt, fail_cnt;
    logic [63:0] held_rdata, exp_exit, exp_cnt_en;
    logic        held_err;
    void'($urandom(73004));
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = 32'h0;
    req_wdata_i = 64'h0;
    req_be_i    = 8'h0;
    rsp_ready_i = 1'b0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    exp_exit    = 64'h0;
    exp_cnt_en  = 64'h0;
    fill_table();
    cycle_limit = stim_q.size() * 40;
    repeat (4) @(posedge clk_i);
    #1 arst_n_i = 1'b1;

    check_value("req_ready_o", 64'(req_ready_o), 64'd1);
    check_value("rsp_valid_o", 64'(rsp_valid_o), 64'd0);
    check_value("uart_psel_o", 64'(uart_psel), 64'd0);
    check_value("uart_penable_o", 64'(uart_penable), 64'd0);
    check_value("exit_o", exit_o, 64'h0);
    check_value("hw_cnt_en_o", hw_cnt_en_o, 64'h0);

    foreach (stim_q[i]) begin
      e           = stim_q[i];
      errs_before = error_cnt;
      psel_before = psel_cnt;
      req_valid_i = 1'b1;
      req_we_i    = e.we;
      req_addr_i  = e.addr;
      req_wdata_i = e.wdata;
      req_be_i    = e.be;
      while (!req_ready_o) step();
      step();
      req_valid_i = 1'b0;
      while (!rsp_valid_o) step();
      held_rdata = rsp_rdata_o;
      held_err   = rsp_err_o;

      // Hold the response back and watch it stay put
      stall = $urandom % 5;
      repeat (stall) begin
        step();
        check_value("rsp_valid_o", 64'(rsp_valid_o), 64'd1);
        check_value("rsp_rdata_o", rsp_rdata_o, held_rdata);
        check_value("rsp_err_o", 64'(rsp_err_o), 64'(held_err));
        check_value("req_ready_o", 64'(req_ready_o), 64'd0);
      end
      rsp_ready_i = 1'b1;
      step();
      rsp_ready_i = 1'b0;

      check_value("rsp_rdata_o", held_rdata, e.exp_rdata);
      check_value("rsp_err_o", 64'(held_err), 64'(e.exp_err));
      if (e.addr[31:12] != 20'hC0000) begin
        check_value("uart_psel_o cycles", 64'(psel_cnt - psel_before), 64'd0);
      end
      if (e.we && e.addr == 32'hD000_0000) exp_exit = e.wdata;
      if (e.we && e.addr == 32'hD000_0008) exp_cnt_en = e.wdata;
      check_value("exit_o", exit_o, exp_exit);
      check_value("hw_cnt_en_o", hw_cnt_en_o, exp_cnt_en);

      if (error_cnt == errs_before) pass_cnt++;
      else fail_cnt++;
      $display("Entry %0d %s 0x%h: %s", i, e.we ? "write" : "read ", e.addr,
               (error_cnt == errs_before) ? "ok" : "FAILED");
    end

    $display("Entries passed: %0d, entries failed: %0d", pass_cnt, fail_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
soc_pkg.sv
soc_xbar.sv
l2_mem.sv
uart_apb_bridge.sv
ctrl_registers.sv
soc_top.sv
tb_uart_model.sv
tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f filelist.f --top-module tb_soc -o tb_soc_sim
./obj_dir/tb_soc_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0
